//--- vlog.f
verilog/i3c_tx_pkg.sv
verilog/scl_timing.sv
verilog/frame_sequencer.sv
verilog/controller_tx.sv
verilog/i3c_tx_top.sv
verif/tb_clock_gen.sv
verif/tb_bus_checker.sv
verif/tb_top.sv

//--- Makefile
# Verilator build for the i3c transmit path

TOOL      := verilator
SIM_FLAGS := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP       := tb_top
RTL_TOP   := i3c_tx_top
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_top.sv
/*
 * testbench top for the i3c transmit path
 * random frames from an lfsr, chained and ignored requests, watchdog and summary
 */

`timescale 1ns/1ps

module tb_top;
    import i3c_tx_pkg::*;

    localparam int  N_FRAMING = 200;
    localparam int  N_CHAIN   = 60;
    localparam int  N_IGNORE  = 20;
    localparam int  N_TOTAL   = N_FRAMING + N_CHAIN + 2 * N_IGNORE;
    localparam longint WATCHDOG_NS =
        longint'(N_TOTAL) * (START_HOLD + 12 * 2 * SCL_HALF) * 8 + 100000;

    logic        clk;
    logic        rst_n;
    logic        tx_start;
    logic [7:0]  tx_data;
    logic        tx_more;
    logic        scl;
    logic        sda;
    logic        busy;
    logic        frame_done;
    logic [15:0] lfsr_state = 16'(77430);

    tb_clock_gen clock_gen_i (.o_clk(clk), .o_rst_n(rst_n));

    i3c_tx_top i3c_tx_top_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_tx_start   (tx_start),
        .i_tx_data    (tx_data),
        .i_tx_more    (tx_more),
        .o_scl        (scl),
        .o_sda        (sda),
        .o_busy       (busy),
        .o_frame_done (frame_done)
    );

    tb_bus_checker checker_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_tx_start   (tx_start),
        .i_scl        (scl),
        .i_sda        (sda),
        .i_busy       (busy),
        .i_frame_done (frame_done)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic strobe(input logic [7:0] data, input logic more);
        @(posedge clk);
        tx_start <= 1'b1;
        tx_data  <= data;
        tx_more  <= more;
        @(posedge clk);
        tx_start <= 1'b0;
    endtask

    task automatic wait_idle();
        do
            @(posedge clk);
        while (busy);
    endtask

    task automatic wait_frame_done();
        do
            @(posedge clk);
        while (!frame_done);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic more, input logic from_sr);
        checker_i.push_expected('{data: data, more: more}, from_sr);
        strobe(data, more);
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        logic [7:0] data;
        logic [7:0] pick;
        logic       chained;
        tx_start = 1'b0;
        tx_data  = '0;
        tx_more  = 1'b0;

        @(posedge rst_n);
        repeat (30) @(posedge clk);
        checker_i.end_of_test("reset_idle");

        for (int i = 0; i < N_FRAMING; i++)
        begin
            draw_bits(8, data);
            wait_idle();
            send_frame(data, 1'b0, 1'b0);
        end
        wait_idle();
        repeat (4) @(posedge clk);
        checker_i.end_of_test("byte_framing");

        // more=1 frames are either chained or left to time out into a stop
        chained = 1'b0;
        for (int i = 0; i < N_CHAIN; i++)
        begin
            draw_bits(8, data);
            draw_bits(1, pick);
            if (!chained)
                wait_idle();
            send_frame(data, pick[0], chained);
            chained = 1'b0;
            if (pick[0])
            begin
                wait_frame_done();
                draw_bits(1, pick);
                chained = (i != N_CHAIN - 1) && pick[0];
            end
        end
        wait_idle();
        repeat (4) @(posedge clk);
        checker_i.end_of_test("repeated_start_chain");

        for (int i = 0; i < N_IGNORE; i++)
        begin
            draw_bits(8, data);
            wait_idle();
            send_frame(data, 1'b0, 1'b0);
            draw_bits(5, pick);
            repeat (int'(pick) + 8) @(posedge clk);
            draw_bits(8, data);
            draw_bits(1, pick);
            // the dut is busy outside any chain window and drops this one
            strobe(data, pick[0]);
        end
        wait_idle();
        repeat (4) @(posedge clk);
        checker_i.end_of_test("ignored_strobe");

        $display("summary: %0d frames checked, %0d frame_done pulses, %0d errors",
                 checker_i.frames_checked, checker_i.done_pulses, checker_i.error_count);
        if (checker_i.error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped finishing frames",
                 WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- verif/tb_bus_checker.sv
/*
 * bus checker
 * decodes start, repeated start, stop and bits from scl/sda
 * and compares each frame with the expected request queue
 */

`timescale 1ns/1ps

module tb_bus_checker
    import i3c_tx_pkg::*;
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_tx_start,
    input logic i_scl,
    input logic i_sda,
    input logic i_busy,
    input logic i_frame_done
);

    tx_req_t     exp_q[$];
    logic        chain_q[$];
    int          error_count = 0;
    int          frames_checked = 0;
    int          done_pulses = 0;
    int          errors_at_last_test = 0;
    int          frames_at_last_test = 0;
    logic        prev_scl = 1'b1;
    logic        prev_sda = 1'b1;
    logic        in_frame = 1'b0;
    logic        after_sr = 1'b0;
    logic        seen_start = 1'b0;
    int          nbits = 0;
    logic [8:0]  bits;

    // odd parity makes the t-bit high when the byte holds an even number of ones
    function automatic logic expected_t_bit(input logic [7:0] data);
        int ones;
        ones = 0;
        for (int k = 0; k < 8; k++)
            ones += data[k];
        return (ones % 2) == 0;
    endfunction

    task automatic push_expected(input tx_req_t r, input logic chained);
        exp_q.push_back(r);
        chain_q.push_back(chained);
    endtask

    task automatic value_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    // ========================================
    // frame compare
    // ========================================

    task automatic close_frame(input logic ended_by_sr);
        tx_req_t exp;
        logic    exp_chained;
        if (nbits != 10)
        begin
            value_error($sformatf("frame carried %0d bits, expected 10", nbits));
        end
        if (exp_q.size() == 0)
        begin
            $display("A frame appeared on the bus at %0t ns with no request queued", $time);
            error_count++;
        end
        else
        begin
            exp         = exp_q.pop_front();
            exp_chained = chain_q.pop_front();
            if (bits[8:1] != exp.data)
                value_error($sformatf("data %02h, expected %02h", bits[8:1], exp.data));
            if (bits[0] != expected_t_bit(exp.data))
                value_error($sformatf("t-bit %b wrong for byte %02h", bits[0], exp.data));
            if (ended_by_sr != exp.more)
                value_error($sformatf("frame end sr=%b, expected more=%b",
                                      ended_by_sr, exp.more));
            if (after_sr != exp_chained)
                value_error($sformatf("frame began with sr=%b, expected chained=%b",
                                      after_sr, exp_chained));
        end
        frames_checked++;
    endtask

    always @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            prev_scl = 1'b1;
            prev_sda = 1'b1;
            in_frame = 1'b0;
            nbits    = 0;
        end
        else
        begin
            if (i_tx_start)
                seen_start = 1'b1;
            // idle lines until the first request
            if (!seen_start && (!i_scl || !i_sda || i_busy))
                value_error($sformatf("not idle after reset, scl=%b sda=%b busy=%b",
                                      i_scl, i_sda, i_busy));
            if (i_frame_done)
                done_pulses++;

            // sda moving under a high scl is always a condition
            if (prev_scl && i_scl && (i_sda != prev_sda))
            begin
                if (!i_sda)
                begin
                    if (in_frame)
                        close_frame(1'b1);
                    after_sr = in_frame;
                    in_frame = 1'b1;
                    nbits    = 0;
                end
                else if (!in_frame)
                begin
                    value_error("stop seen without a start");
                end
                else
                begin
                    // an sr with no byte chained is closed by a stop
                    if (!(nbits == 0 && after_sr))
                        close_frame(1'b0);
                    in_frame = 1'b0;
                    after_sr = 1'b0;
                end
            end
            else if (!prev_scl && i_scl && in_frame)
            begin
                // the tenth rise only sets up the end condition
                if (nbits < 9)
                    bits[8 - nbits] = i_sda;
                nbits++;
            end
            prev_scl = i_scl;
            prev_sda = i_sda;
        end
    end

    // ========================================
    // per test summary
    // ========================================

    task automatic end_of_test(input string name);
        if (exp_q.size() != 0)
        begin
            $display("%0d expected frames never appeared on the bus", exp_q.size());
            error_count++;
            exp_q.delete();
            chain_q.delete();
        end
        if (done_pulses != frames_checked)
        begin
            $display("Saw %0d frame_done pulses for %0d frames on the bus",
                     done_pulses, frames_checked);
            error_count++;
            done_pulses = frames_checked;
        end
        $display("test %s finished: %0d frames, %0d errors", name,
                 frames_checked - frames_at_last_test, error_count - errors_at_last_test);
        frames_at_last_test = frames_checked;
        errors_at_last_test = error_count;
    endtask

endmodule

//--- verif/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * 8 ns clock, active low reset held for 8 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_rst_n
);

    initial
    begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

    always #4 o_clk = ~o_clk;

endmodule

//--- verilog/i3c_tx_top.sv
/*
 * i3c/i2c transmit path top level
 * scl timing and frame sequencer run side by side, the serializer drives sda
 */

`timescale 1ns/1ps

module i3c_tx_top
    import i3c_tx_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_tx_start,
    input  logic [DATA_W-1:0] i_tx_data,
    input  logic              i_tx_more,
    output logic              o_scl,
    output logic              o_sda,
    output logic              o_busy,
    output logic              o_frame_done
);

    scl_t             scl;
    logic             timer_cas;
    ser_mode_e        ser_mode;
    logic             ser_en;
    tx_req_t          req;
    logic [BIT_W-1:0] ser_count;
    logic             ser_count_done;
    logic             scl_run;
    logic             ser_mode_done;
    logic             start_pattern;
    logic             stop_pattern;
    logic             ser_s_data;

    scl_timing scl_timing_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_scl_run       (scl_run),
        .i_start_pattern (start_pattern),
        .i_stop_pattern  (stop_pattern),
        .o_scl           (scl),
        .o_timer_cas     (timer_cas)
    );

    frame_sequencer frame_sequencer_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_tx_start       (i_tx_start),
        .i_tx_data        (i_tx_data),
        .i_tx_more        (i_tx_more),
        .i_scl            (scl),
        .i_ser_mode_done  (ser_mode_done),
        .o_ser_mode       (ser_mode),
        .o_ser_en         (ser_en),
        .o_req            (req),
        .o_ser_count      (ser_count),
        .o_ser_count_done (ser_count_done),
        .o_scl_run        (scl_run),
        .o_busy           (o_busy),
        .o_frame_done     (o_frame_done)
    );

    controller_tx controller_tx_i (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_scl            (scl),
        .i_ser_en         (ser_en),
        .i_ser_mode       (ser_mode),
        .i_ser_count      (ser_count),
        .i_ser_count_done (ser_count_done),
        .i_req            (req),
        .i_timer_cas      (timer_cas),
        .o_ser_s_data     (ser_s_data),
        .o_ser_mode_done  (ser_mode_done),
        .o_start_pattern  (start_pattern),
        .o_stop_pattern   (stop_pattern)
    );

    assign o_scl = scl.level;
    assign o_sda = ser_s_data;

endmodule

//--- verilog/controller_tx.sv
/*
 * controller transmit serializer
 * forms sda for the current mode and pulses mode done to advance the sequencer,
 * also requests start/stop patterns from the scl timing block
 */

`timescale 1ns/1ps

module controller_tx
    import i3c_tx_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  scl_t             i_scl,
    input  logic             i_ser_en,
    input  ser_mode_e        i_ser_mode,
    input  logic [BIT_W-1:0] i_ser_count,
    input  logic             i_ser_count_done,
    input  tx_req_t          i_req,
    input  logic             i_timer_cas,
    output logic             o_ser_s_data,
    output logic             o_ser_mode_done,
    output logic             o_start_pattern,
    output logic             o_stop_pattern
);

    // ========================================
    // serializer
    // ========================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin : proc_serializer
        if (!i_rst_n)
        begin
            o_ser_s_data    <= 1'b1;
            o_ser_mode_done <= 1'b0;
            o_start_pattern <= 1'b0;
            o_stop_pattern  <= 1'b0;
        end
        else if (i_ser_en)
        begin
            // strobes and pattern requests drop unless the mode keeps them up
            o_ser_mode_done <= 1'b0;
            o_start_pattern <= 1'b0;
            o_stop_pattern  <= 1'b0;

            case (i_ser_mode)
                START_BIT:
                begin
                    o_ser_s_data <= 1'b1;
                    // sda falls under a high scl, then hold until the timer ends it
                    if (i_scl.level)
                    begin
                        o_ser_s_data <= 1'b0;
                        if (i_timer_cas)
                            o_ser_mode_done <= 1'b1;
                        else if (!o_ser_mode_done)
                            o_start_pattern <= 1'b1;
                    end
                end

                SERIALIZING:
                begin
                    // msb first, data only moves while scl is low
                    if (!i_scl.level)
                        o_ser_s_data <= i_req.data[i_ser_count];
                    o_ser_mode_done <= i_ser_count_done && i_scl.neg_edge;
                end

                PARITY:
                begin
                    // t-bit, odd parity over the byte
                    if (!i_scl.level)
                        o_ser_s_data <= ~^i_req.data;
                    o_ser_mode_done <= i_scl.neg_edge;
                end

                STOP:
                begin
                    if (i_scl.level)
                    begin
                        o_stop_pattern  <= 1'b1;
                        o_ser_s_data    <= 1'b1;
                        o_ser_mode_done <= !o_ser_mode_done;
                    end
                    else
                    begin
                        o_ser_s_data <= 1'b0;
                    end
                end

                REPEATED_START:
                begin
                    // high while scl is low, falls once scl is back high
                    o_ser_s_data    <= !i_scl.level;
                    o_ser_mode_done <= i_scl.pos_edge;
                end

                CTRL_ACK:
                begin
                    o_ser_s_data    <= 1'b0;
                    o_ser_mode_done <= i_scl.pos_edge;
                end

                CTRL_NACK:
                begin
                    o_ser_s_data    <= 1'b1;
                    o_ser_mode_done <= i_scl.pos_edge;
                end

                HOLD_ZERO:
                begin
                    o_ser_s_data <= 1'b0;
                end
            endcase
        end
        else
        begin
            // bus idle, sda released
            o_ser_s_data    <= 1'b1;
            o_ser_mode_done <= 1'b0;
            o_start_pattern <= 1'b0;
            o_stop_pattern  <= 1'b0;
        end
    end

endmodule

//--- verilog/frame_sequencer.sv
/*
 * frame sequencer
 * steps the serializer through start, data, t-bit and stop or repeated start,
 * latches the request and counts the data bits on scl falling edges
 */

`timescale 1ns/1ps

module frame_sequencer
    import i3c_tx_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_tx_start,
    input  logic [DATA_W-1:0] i_tx_data,
    input  logic              i_tx_more,
    input  scl_t              i_scl,
    input  logic              i_ser_mode_done,
    output ser_mode_e         o_ser_mode,
    output logic              o_ser_en,
    output tx_req_t           o_req,
    output logic [BIT_W-1:0]  o_ser_count,
    output logic              o_ser_count_done,
    output logic              o_scl_run,
    output logic              o_busy,
    output logic              o_frame_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_SER,
        ST_PARITY,
        ST_STOP,
        ST_RSTART,
        ST_CHAIN
    } state_e;

    state_e             state;
    state_e             state_nxt;
    logic               accept;
    logic               chain_timeout;
    logic [CHAIN_W-1:0] wait_cnt;
    logic               bit_hi;

    // new requests only from idle or inside the chain window
    assign accept        = i_tx_start && (state == ST_IDLE || state == ST_CHAIN);
    assign chain_timeout = (wait_cnt == CHAIN_W'(CHAIN_WAIT - 1));

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (accept) state_nxt = ST_START;
            ST_START:  if (i_ser_mode_done) state_nxt = ST_SER;
            ST_SER:    if (i_ser_mode_done) state_nxt = ST_PARITY;
            ST_PARITY:
            begin
                if (i_ser_mode_done)
                    state_nxt = o_req.more ? ST_RSTART : ST_STOP;
            end
            ST_STOP:   if (i_ser_mode_done) state_nxt = ST_IDLE;
            ST_RSTART: if (i_ser_mode_done) state_nxt = ST_CHAIN;
            ST_CHAIN:
            begin
                if (accept)
                    state_nxt = ST_START;
                else if (chain_timeout)
                    state_nxt = ST_STOP;
            end
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // ========================================
    // state, bit counter, frame done
    // ========================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state        <= ST_IDLE;
            wait_cnt     <= '0;
            o_ser_count  <= '1;
            bit_hi       <= 1'b0;
            o_frame_done <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            wait_cnt <= (state == ST_CHAIN) ? wait_cnt + 1'b1 : '0;

            // a stop after a timed-out chain closes no new frame
            o_frame_done <= i_ser_mode_done &&
                            ((state == ST_STOP && !o_req.more) || state == ST_RSTART);

            if (state != ST_SER)
            begin
                o_ser_count <= '1;
                bit_hi      <= 1'b0;
            end
            else if (i_scl.pos_edge)
            begin
                bit_hi <= 1'b1;
            end
            else if (i_scl.neg_edge)
            begin
                // first fall after start only launches bit 7
                bit_hi <= 1'b0;
                if (bit_hi && o_ser_count != '0)
                    o_ser_count <= o_ser_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
            o_req <= '{data: i_tx_data, more: i_tx_more};
    end

    // last bit has been on the bus through its high phase
    assign o_ser_count_done = bit_hi && (o_ser_count == '0);

    assign o_ser_en  = (state != ST_IDLE);
    assign o_busy    = (state != ST_IDLE);
    assign o_scl_run = (state == ST_SER) || (state == ST_PARITY) ||
                       (state == ST_STOP) || (state == ST_RSTART);

    always_comb
    begin
        case (state)
            ST_SER:    o_ser_mode = SERIALIZING;
            ST_PARITY: o_ser_mode = PARITY;
            ST_STOP:   o_ser_mode = STOP;
            ST_RSTART: o_ser_mode = REPEATED_START;
            // sda stays low under a parked scl until the next byte or a stop
            ST_CHAIN:  o_ser_mode = REPEATED_START;
            default:   o_ser_mode = START_BIT;
        endcase
    end

endmodule

//--- verilog/scl_timing.sv
/*
 * scl timing generator
 * divides the system clock into scl, flags its edges, parks scl high
 * during start/stop patterns and times the start hold
 */

`timescale 1ns/1ps

module scl_timing
    import i3c_tx_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_scl_run,
    input  logic i_start_pattern,
    input  logic i_stop_pattern,
    output scl_t o_scl,
    output logic o_timer_cas
);

    logic [HALF_W-1:0] half_cnt;
    logic [HOLD_W-1:0] hold_cnt;
    logic              park_high;

    // scl is held high whenever the sequencer stops the clock
    // or the serializer is forming a start or stop condition
    assign park_high = !i_scl_run || i_start_pattern || i_stop_pattern;

    // ========================================
    // scl divider and edge strobes
    // ========================================

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_scl.level    <= 1'b1;
            o_scl.pos_edge <= 1'b0;
            o_scl.neg_edge <= 1'b0;
            half_cnt       <= '0;
        end
        else
        begin
            o_scl.pos_edge <= 1'b0;
            o_scl.neg_edge <= 1'b0;
            if (park_high)
            begin
                half_cnt <= '0;
                // release a low scl straight away
                if (!o_scl.level)
                begin
                    o_scl.level    <= 1'b1;
                    o_scl.pos_edge <= 1'b1;
                end
            end
            else if (half_cnt == HALF_W'(SCL_HALF - 1))
            begin
                half_cnt       <= '0;
                o_scl.level    <= !o_scl.level;
                o_scl.pos_edge <= !o_scl.level;
                o_scl.neg_edge <= o_scl.level;
            end
            else
            begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // start hold timer
    // ========================================

    // counts while the start pattern is up, saturates at START_HOLD
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            hold_cnt    <= '0;
            o_timer_cas <= 1'b0;
        end
        else
        begin
            if (!i_start_pattern)
                hold_cnt <= '0;
            else if (hold_cnt != HOLD_W'(START_HOLD))
                hold_cnt <= hold_cnt + 1'b1;

            // single pulse, the count has moved past the match next cycle
            o_timer_cas <= i_start_pattern && (hold_cnt == HOLD_W'(START_HOLD - 1));
        end
    end

endmodule

//--- verilog/i3c_tx_pkg.sv
/*
 * i3c transmit path shared definitions
 * serializer mode encodings, scl and request bundles, bus timing constants
 */

package i3c_tx_pkg;

    // ========================================
    // bus timing
    // ========================================

    // system clocks per scl half period
    localparam int SCL_HALF   = 4;
    // sda low with scl high before the start is complete
    localparam int START_HOLD = 6;
    // bit counter width, counts 7 down to 0
    localparam int BIT_W      = 3;
    localparam int DATA_W     = 8;

    // derived counter widths
    localparam int HALF_W     = $clog2(SCL_HALF);
    localparam int HOLD_W     = $clog2(START_HOLD + 1);
    // window for chaining a byte after a repeated start, one scl period
    localparam int CHAIN_WAIT = 2 * SCL_HALF;
    localparam int CHAIN_W    = $clog2(CHAIN_WAIT + 1);

    // ========================================
    // types
    // ========================================

    // serializer modes, encodings shared with the rest of the controller
    typedef enum logic [2:0] {
        START_BIT      = 3'b000,
        SERIALIZING    = 3'b001,
        STOP           = 3'b010,
        PARITY         = 3'b011,
        HOLD_ZERO      = 3'b100,
        CTRL_NACK      = 3'b101,
        REPEATED_START = 3'b110,
        CTRL_ACK       = 3'b111
    } ser_mode_e;

    // scl level plus one-cycle strobes, asserted in the cycle the level changes
    typedef struct packed {
        logic level;
        logic pos_edge;
        logic neg_edge;
    } scl_t;

    // one transfer request; more selects repeated start over stop
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              more;
    } tx_req_t;

endpackage
